// File: filelist.f
+incdir+source
source/bus_pkg.sv
source/fetch_pkg.sv
source/icache_ctrl.sv
source/icache_mem.sv
source/fetch_stage.sv
source/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the fetch front end testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module fetch_tb -f filelist.f -o fetch_sim \
	&& ./obj_dir/fetch_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
	&& { echo "Simulation result: PASS"; exit 0; } \
	|| { echo "Simulation result: FAIL"; exit 1; }

// File: dv/fetch_tb.sv
// Fetch front end testbench with clock, reset, tagged memory model, redirects, reference model and checks

`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_tb;

	import bus_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int SEED            = 88;
	localparam int SEQ_LEN         = 64;      // Straight line from PC 0
	localparam int LOOP_LEN        = 16;      // Loop body of eight blocks
	localparam int RAND_LEN        = 1500;    // Instructions under random redirects
	localparam int WATCHDOG_CYCLES = (SEQ_LEN + 2 * LOOP_LEN + RAND_LEN) * 20;

	logic         clock = 1'b0;
	logic         reset;
	mem_tag_t     mem_response = '0;
	mem_block_t   mem_data = '0;
	mem_tag_t     mem_tag = '0;
	mem_command_t mem_command;
	mem_addr_t    mem_addr;
	logic         redirect_en;
	logic [63:0]  redirect_pc;
	logic [63:0]  fetch_npc;
	logic [31:0]  fetch_ir;
	logic         fetch_valid;

	mem_block_t   mem_image [8192];         // 64 KiB as 8 K blocks
	logic [63:0]  exp_q [$];                // Expected PC stream
	logic         passed = 1'b0;
	logic         fail_shown = 1'b0;

	// Memory model state
	logic         load_busy = 1'b0;
	mem_tag_t     load_tag = '0;
	mem_addr_t    load_addr = '0;
	int           load_wait = 0;
	logic         retry_due = 1'b0;         // Rejected last cycle so the same load is due
	mem_addr_t    retry_addr = '0;

	fetch_top fetch_top_i (
		.clock        (clock),
		.reset        (reset),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.redirect_en  (redirect_en),
		.redirect_pc  (redirect_pc),
		.fetch_npc    (fetch_npc),
		.fetch_ir     (fetch_ir),
		.fetch_valid  (fetch_valid)
	);

	bind fetch_top fetch_asserts fetch_asserts_i (
		.clock       (clock),
		.reset       (reset),
		.mem_command (mem_command),
		.mem_addr    (mem_addr),
		.redirect_en (redirect_en),
		.fetch_valid (fetch_valid)
	);

	initial
	begin
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			fail_shown = 1'b1;
			$display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Low word sits at the lower address
	function automatic logic [31:0] word_at(input logic [63:0] pc);
		mem_block_t blk;
		blk = mem_image[pc[15:3]];
		return pc[2] ? blk[63:32] : blk[31:0];
	endfunction

	task automatic count_outputs(input int count);
		int seen;
		seen = 0;
		while (seen < count)
		begin
			@(posedge clock);
			if (fetch_valid)
				seen++;
		end
	endtask

	task automatic pulse_redirect(input logic [63:0] target);
		redirect_en <= 1'b1;
		redirect_pc <= target;
		@(posedge clock);
		redirect_en <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model checking every valid output
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		logic [63:0] exp_pc;
		if (reset)
		begin
			exp_q.delete();
			exp_q.push_back(64'd0);          // Fetch starts at 0
		end
		else
		begin
			if (fetch_valid)
			begin
				exp_pc = exp_q.pop_front();
				check_value("fetch_npc", fetch_npc, exp_pc + 64'd4);
				check_value("fetch_ir", 64'(fetch_ir), 64'(word_at(exp_pc)));
				exp_q.push_back(exp_pc + 64'd4);
			end
			if (redirect_en)                  // Old stream ends here
			begin
				exp_q.delete();
				exp_q.push_back(redirect_pc);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tagged memory with random accept and latency
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin
		if (reset)
		begin
			mem_response <= '0;
			mem_tag      <= '0;
			load_busy    = 1'b0;
			retry_due    = 1'b0;
		end
		else
		begin
			if (retry_due)
			begin
				check_value("mem_command", 64'(mem_command), 64'(BUS_LOAD));
				check_value("mem_addr", mem_addr, retry_addr);
			end
			retry_due  = (mem_command == BUS_LOAD) && (mem_response == '0) && !redirect_en;
			retry_addr = mem_addr;

			// Data return for the load in flight
			mem_tag  <= '0;
			mem_data <= {$urandom, $urandom};   // Junk while no tag
			if (load_busy)
			begin
				if (load_wait == 0)
				begin
					mem_tag   <= load_tag;
					mem_data  <= mem_image[load_addr[15:3]];
					load_busy = 1'b0;
				end
				else
					load_wait--;
			end

			if ((mem_command == BUS_LOAD) && (mem_response != '0))
			begin
				load_busy = 1'b1;
				load_tag  = mem_response;
				load_addr = mem_addr;
				load_wait = 1 + $urandom % 7;    // Data 2 to 8 cycles out
			end

			// About one in four rejected
			mem_response <= ($urandom % 4 == 0) ? '0 : mem_tag_t'(1 + $urandom % 15);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [63:0] loop_base;
		int          seen;

		void'($urandom(SEED));
		for (int i = 0; i < 8192; i++)
			mem_image[i] = {$urandom, $urandom};
		reset       = 1'b1;
		redirect_en = 1'b0;
		redirect_pc = '0;

		repeat (8) @(posedge clock);
		check_value("mem_command", 64'(mem_command), 64'(BUS_NONE));   // Quiet bus in reset
		reset <= 1'b0;

		@(posedge clock);                     // First cycle out of reset
		check_value("fetch_valid", 64'(fetch_valid), 64'd0);
		check_value("fetch_ir", 64'(fetch_ir), 64'(`NOOP_INST));
		check_value("mem_command", 64'(mem_command), 64'(BUS_LOAD));   // Cold miss at PC 0
		check_value("mem_addr", mem_addr, 64'd0);

		count_outputs(SEQ_LEN);

		// First pass over the loop body fills its lines
		loop_base = 64'($urandom & 32'h0000_FEF8);
		pulse_redirect(loop_base);
		count_outputs(LOOP_LEN);

		// Second pass hits throughout at one instruction per cycle
		pulse_redirect(loop_base);
		@(posedge clock);                     // Redirect bubble
		for (int k = 1; k <= LOOP_LEN; k++)
		begin
			@(posedge clock);
			check_value("fetch_valid", 64'(fetch_valid), 64'd1);
			if (k < LOOP_LEN)                 // Last one sits past the loop
				check_value("mem_command", 64'(mem_command), 64'(BUS_NONE));
		end

		// Random redirects
		seen = 0;
		while (seen < RAND_LEN)
		begin
			@(posedge clock);
			if (fetch_valid)
				seen++;
			if ($urandom % 16 == 0)
			begin
				redirect_en <= 1'b1;
				redirect_pc <= 64'($urandom & 32'h0000_FFFC);
			end
			else
				redirect_en <= 1'b0;
		end
		@(posedge clock);
		redirect_en <= 1'b0;
		repeat (4) @(posedge clock);

		passed = 1'b1;
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_shown = 1'b1;
		$display("Watchdog expired before all planned instructions were fetched");
		$display("*** TEST FAILED ***");
		$fatal(1, "Timeout");
	end

	// Early stop from a bound assertion
	final
	begin
		if (!passed && !fail_shown)
			$display("*** TEST FAILED ***");
	end

endmodule

// File: dv/fetch_asserts.sv
// Bus and fetch output assertions, bound into the fetch top level

`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_asserts (
	input logic                  clock,
	input logic                  reset,
	input bus_pkg::mem_command_t mem_command,
	input bus_pkg::mem_addr_t    mem_addr,
	input logic                  redirect_en,
	input logic                  fetch_valid
);

	import bus_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Memory bus
	////////////////////////////////////////////////////////////////////////////

	// Fetch only ever reads
	no_store: assert property (@(posedge clock) disable iff (reset)
		mem_command != BUS_STORE)
		else $error("BUS_STORE driven by the fetch front end");

	load_aligned: assert property (@(posedge clock) disable iff (reset)
		(mem_command == BUS_LOAD) |-> (mem_addr[`BLOCK_OFFSET_W-1:0] == '0))
		else $error("Load address not block aligned");

	////////////////////////////////////////////////////////////////////////////
	// Fetch output bubbles
	////////////////////////////////////////////////////////////////////////////

	redirect_bubble: assert property (@(posedge clock) disable iff (reset)
		redirect_en |=> !fetch_valid)
		else $error("fetch_valid high right after a redirect");

	reset_bubble: assert property (@(posedge clock)
		$fell(reset) |-> !fetch_valid)     // First cycle out of reset
		else $error("fetch_valid high in the first cycle after reset");

endmodule

// File: source/fetch_top.sv
// Fetch front end top: cache controller, cache store and fetch stage on the memory bus

`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_top (
	input  logic                  clock,
	input  logic                  reset,

	// Memory bus
	input  bus_pkg::mem_tag_t     mem_response,
	input  bus_pkg::mem_block_t   mem_data,
	input  bus_pkg::mem_tag_t     mem_tag,
	output bus_pkg::mem_command_t mem_command,
	output bus_pkg::mem_addr_t    mem_addr,

	// Redirect from execute
	input  logic                  redirect_en,
	input  fetch_pkg::pc_t        redirect_pc,

	// Toward decode
	output fetch_pkg::pc_t        fetch_npc,
	output fetch_pkg::inst_t      fetch_ir,
	output logic                  fetch_valid
);

	import bus_pkg::*;
	import fetch_pkg::*;

	// Controller to store
	cache_idx_t rd_idx;
	cache_tag_t rd_tag;
	mem_block_t rd_data;
	logic       rd_hit;
	logic       wr_en;
	cache_idx_t wr_idx;
	cache_tag_t wr_tag;

	// Fetch stage to controller
	pc_t        fetch_addr;
	mem_block_t hit_block;
	logic       hit_valid;

	////////////////////////////////////////////////////////////////////////////
	// Cache
	////////////////////////////////////////////////////////////////////////////

	icache_ctrl icache_ctrl_i (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.rd_idx       (rd_idx),
		.rd_tag       (rd_tag),
		.rd_data      (rd_data),
		.rd_hit       (rd_hit),
		.wr_en        (wr_en),
		.wr_idx       (wr_idx),
		.wr_tag       (wr_tag),
		.hit_block    (hit_block),
		.hit_valid    (hit_valid)
	);

	icache_mem icache_mem_i (
		.clock   (clock),
		.reset   (reset),
		.rd_idx  (rd_idx),
		.rd_tag  (rd_tag),
		.rd_data (rd_data),
		.rd_hit  (rd_hit),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_tag  (wr_tag),
		.wr_data (mem_data)           // Fill block straight from the bus
	);

	////////////////////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////////////////////

	fetch_stage fetch_stage_i (
		.clock       (clock),
		.reset       (reset),
		.redirect_en (redirect_en),
		.redirect_pc (redirect_pc),
		.hit_block   (hit_block),
		.hit_valid   (hit_valid),
		.fetch_addr  (fetch_addr),
		.fetch_npc   (fetch_npc),
		.fetch_ir    (fetch_ir),
		.fetch_valid (fetch_valid)
	);

endmodule

// File: source/fetch_stage.sv
// Fetch stage: PC register, redirect, word select, fetch/decode output register

`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_stage (
	input  logic                clock,
	input  logic                reset,

	// Branch target from execute
	input  logic                redirect_en,
	input  fetch_pkg::pc_t      redirect_pc,

	// Cache answer for fetch_addr
	input  bus_pkg::mem_block_t hit_block,
	input  logic                hit_valid,

	output fetch_pkg::pc_t      fetch_addr,
	output fetch_pkg::pc_t      fetch_npc,
	output fetch_pkg::inst_t    fetch_ir,
	output logic                fetch_valid
);

	import bus_pkg::*;
	import fetch_pkg::*;

	pc_t   pc;
	pc_t   pc_plus4;
	inst_t fetch_word;

	assign fetch_addr = pc;
	assign pc_plus4   = pc + pc_t'(4);

	// PC bit 2 picks the word inside the block
	assign fetch_word = pc[`BLOCK_OFFSET_W-1] ? hit_block[`INST_W +: `INST_W]
		: hit_block[0 +: `INST_W];

	////////////////////////////////////////////////////////////////////////////
	// Program counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0;
		else if (redirect_en)
			pc <= redirect_pc;          // Redirect wins over a hit
		else if (hit_valid)
			pc <= pc_plus4;
		// Miss holds the PC
	end

	////////////////////////////////////////////////////////////////////////////
	// Fetch/decode register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetch_npc   <= '0;
			fetch_ir    <= `NOOP_INST;
			fetch_valid <= 1'b0;
		end
		else if (hit_valid && !redirect_en)
		begin
			fetch_npc   <= pc_plus4;
			fetch_ir    <= fetch_word;
			fetch_valid <= 1'b1;
		end
		else
		begin
			fetch_ir    <= `NOOP_INST;  // Bubble, npc keeps last value
			fetch_valid <= 1'b0;
		end
	end

endmodule

// File: source/icache_mem.sv
// Instruction cache store: valid bits, tag array, block array

`timescale 1ns/100ps

`include "fetch_defines.svh"

module icache_mem (
	input  logic                  clock,
	input  logic                  reset,

	// Lookup, answered in the same cycle
	input  fetch_pkg::cache_idx_t rd_idx,
	input  fetch_pkg::cache_tag_t rd_tag,
	output bus_pkg::mem_block_t   rd_data,
	output logic                  rd_hit,

	// Fill from memory
	input  logic                  wr_en,
	input  fetch_pkg::cache_idx_t wr_idx,
	input  fetch_pkg::cache_tag_t wr_tag,
	input  bus_pkg::mem_block_t   wr_data
);

	import bus_pkg::*;
	import fetch_pkg::*;

	logic [`CACHE_LINES-1:0] line_valid;
	cache_tag_t              tags   [`CACHE_LINES];
	mem_block_t              blocks [`CACHE_LINES];

	////////////////////////////////////////////////////////////////////////////
	// Read
	////////////////////////////////////////////////////////////////////////////

	assign rd_data = blocks[rd_idx];
	assign rd_hit  = line_valid[rd_idx] && (tags[rd_idx] == rd_tag);

	////////////////////////////////////////////////////////////////////////////
	// Fill, visible from the next cycle on
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			line_valid <= '0;           // Cold cache
		else if (wr_en)
			line_valid[wr_idx] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (wr_en)
		begin
			tags[wr_idx]   <= wr_tag;
			blocks[wr_idx] <= wr_data;  // Replaces whatever was there
		end
	end

endmodule

// File: source/icache_ctrl.sv
// Instruction cache controller with miss detect, load issue and retry, tag tracking and fill

`timescale 1ns/100ps

`include "fetch_defines.svh"

module icache_ctrl (
	input  logic                  clock,
	input  logic                  reset,

	// From the fetch stage
	input  fetch_pkg::pc_t        fetch_addr,

	// Memory bus
	input  bus_pkg::mem_tag_t     mem_response,
	input  bus_pkg::mem_tag_t     mem_tag,
	output bus_pkg::mem_command_t mem_command,
	output bus_pkg::mem_addr_t    mem_addr,

	// Cache store read side
	output fetch_pkg::cache_idx_t rd_idx,
	output fetch_pkg::cache_tag_t rd_tag,
	input  bus_pkg::mem_block_t   rd_data,
	input  logic                  rd_hit,

	// Cache store fill side (data comes from mem_data at the top)
	output logic                  wr_en,
	output fetch_pkg::cache_idx_t wr_idx,
	output fetch_pkg::cache_tag_t wr_tag,

	// Back to the fetch stage
	output bus_pkg::mem_block_t   hit_block,
	output logic                  hit_valid
);

	import bus_pkg::*;
	import fetch_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;
	mem_tag_t    pend_tag;            // Tag of the load in flight
	cache_idx_t  pend_idx;            // Line the fill goes to
	cache_tag_t  pend_line_tag;       // Tag written with the fill
	logic        issue_load;
	logic        load_accepted;
	logic        fill_match;

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	assign rd_idx = fetch_addr[`BLOCK_OFFSET_W +: `CACHE_IDX_W];
	assign rd_tag = fetch_addr[`BLOCK_OFFSET_W + `CACHE_IDX_W +: `CACHE_TAG_W];

	assign hit_block = rd_data;       // Store output as is
	assign hit_valid = rd_hit;

	////////////////////////////////////////////////////////////////////////////
	// Load request
	////////////////////////////////////////////////////////////////////////////

	// Miss with nothing outstanding and out of reset repeats every cycle until accepted
	assign issue_load = !reset && (state == IDLE) && !rd_hit;

	assign mem_command = issue_load ? BUS_LOAD : BUS_NONE;
	assign mem_addr    = {fetch_addr[`FETCH_ADDR_W-1:`BLOCK_OFFSET_W],
		{`BLOCK_OFFSET_W{1'b0}}};                 // Block aligned

	assign load_accepted = issue_load && (mem_response != `MEM_NO_TAG);

	// Only the tag of our own load counts
	assign fill_match = (state == WAIT_DATA) && (mem_tag != `MEM_NO_TAG) &&
		(mem_tag == pend_tag);

	// Fill goes to the recorded line even if the PC moved on
	assign wr_en  = fill_match;
	assign wr_idx = pend_idx;
	assign wr_tag = pend_line_tag;

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:      if (load_accepted) state_nxt = WAIT_DATA;
			WAIT_DATA: if (fill_match) state_nxt = IDLE;
			default:   state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state    <= IDLE;
			pend_tag <= `MEM_NO_TAG;
		end
		else
		begin
			state <= state_nxt;
			if (load_accepted)
				pend_tag <= mem_response;   // Remember who answers
		end
	end

	// Miss line captured with the accepted load
	always_ff @(posedge clock)
	begin
		if (load_accepted)
		begin
			pend_idx      <= rd_idx;
			pend_line_tag <= rd_tag;
		end
	end

endmodule

// File: source/fetch_pkg.sv
// Fetch and instruction cache types: instruction, PC, line index/tag, controller states

`include "fetch_defines.svh"

package fetch_pkg;

	// Raw instruction word
	typedef logic [`INST_W-1:0] inst_t;

	// Program counter, byte address
	typedef logic [`FETCH_ADDR_W-1:0] pc_t;

	////////////////////////////////////////////////////////////////////////
	// Cache address split
	//   [15:8] line tag, [7:3] line index, [2:0] byte in block
	////////////////////////////////////////////////////////////////////////

	typedef logic [`CACHE_IDX_W-1:0] cache_idx_t;
	typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;

	// Miss handling states of the cache controller
	typedef enum logic
	{
		IDLE      = 1'b0,             // Free to issue a load on a miss
		WAIT_DATA = 1'b1              // One load outstanding, waiting on its tag
	} ctrl_state_t;

endpackage

// File: source/bus_pkg.sv
// Memory bus types: command enum, tag, address and data block

`include "fetch_defines.svh"

package bus_pkg;

	// Command driven toward memory
	typedef enum logic [1:0]
	{
		BUS_NONE  = `BUS_CMD_NONE,    // Nothing this cycle
		BUS_LOAD  = `BUS_CMD_LOAD,    // Block read
		BUS_STORE = `BUS_CMD_STORE    // Never issued by fetch
	} mem_command_t;

	// Zero means no tag on both the response and the data side
	typedef logic [`TAG_W-1:0] mem_tag_t;

	// Byte address, block aligned when a load is driven
	typedef logic [`FETCH_ADDR_W-1:0] mem_addr_t;

	// One memory block, low word at the lower address
	typedef logic [`BLOCK_W-1:0] mem_block_t;

endpackage

// File: source/fetch_defines.svh
// Fetch front end macros: widths, cache geometry, bus codes, no-op word

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

`define FETCH_ADDR_W    64            // Byte address and PC width
`define INST_W          32            // One instruction word
`define BLOCK_W         64            // Memory block, two instructions
`define TAG_W           4             // Bus response / data tag

////////////////////////////////////////////////////////////////////////////
// Cache geometry
////////////////////////////////////////////////////////////////////////////

`define BLOCK_OFFSET_W  3             // Byte offset inside a block
`define CACHE_IDX_W     5             // Address bits 7:3
`define CACHE_TAG_W     8             // Address bits 15:8
`define CACHE_LINES     32            // Direct mapped, one block per line

////////////////////////////////////////////////////////////////////////////
// Bus codes
////////////////////////////////////////////////////////////////////////////

`define BUS_CMD_NONE    2'h0
`define BUS_CMD_LOAD    2'h1
`define BUS_CMD_STORE   2'h2          // Encoding reserved on the bus
`define MEM_NO_TAG      4'h0          // Rejected load / idle data bus

// Shown on fetch_ir while the output register is empty
`define NOOP_INST       32'h47ff041f

`endif
